// ==== source/conv_pkg.sv ====
package conv_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////
  localparam int PIXEL_WIDTH = 8;
  localparam int SUM_WIDTH = 24;

  localparam int IMAGE_WIDTH = 5;
  localparam int IMAGE_HEIGHT = 5;
  localparam int CHANNEL_NUM_IN = 2;
  localparam int CHANNEL_NUM_OUT = 2;
  localparam int KERNEL = 3;

  typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
  typedef logic signed [PIXEL_WIDTH-1:0] weight_t;
  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  // Frame store phases
  typedef enum logic [1:0] {FS_FILLING, FS_REPLAYING, FS_GRANTING} frame_state_t;

  // One window result of one input channel, MAC to adder
  typedef struct packed {
    sum_t value;
    logic ic;
    logic last;
  } partial_t;

endpackage

// ==== source/conv_frame_store.sv ====
`timescale 1ns/1ns

module conv_frame_store #(
  parameter int IMAGE_WIDTH = conv_pkg::IMAGE_WIDTH,
  parameter int IMAGE_HEIGHT = conv_pkg::IMAGE_HEIGHT,
  parameter int CHANNEL_NUM_IN = conv_pkg::CHANNEL_NUM_IN,
  parameter int CHANNEL_NUM_OUT = conv_pkg::CHANNEL_NUM_OUT
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             in_valid,
  input  conv_pkg::pixel_t in_pixel,
  output logic             in_credit,
  output logic             fs_valid,
  output conv_pkg::pixel_t fs_pixel,
  output logic             fs_oc,
  output logic             fs_ic
);

  localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_HEIGHT;
  localparam int FRAME_SIZE = IMAGE_SIZE * CHANNEL_NUM_IN;
  localparam int ADDR_W = $clog2(FRAME_SIZE);
  localparam int POS_W = $clog2(IMAGE_SIZE);

  conv_pkg::pixel_t mem [FRAME_SIZE];
  conv_pkg::frame_state_t state;
  logic [ADDR_W-1:0] grant_cnt;
  logic [ADDR_W-1:0] wr_cnt;
  logic [ADDR_W-1:0] rd_addr;
  logic [POS_W-1:0] pos_cnt;
  logic ic_cnt;
  logic oc_cnt;
  logic replay_step;

  assign replay_step = (state == conv_pkg::FS_REPLAYING) && !stall;

  //////////////////////////////
  // Phase control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_pkg::FS_GRANTING;
      grant_cnt <= '0;
      wr_cnt <= '0;
      rd_addr <= '0;
      pos_cnt <= '0;
      ic_cnt <= 1'b0;
      oc_cnt <= 1'b0;
      in_credit <= 1'b0;
      fs_valid <= 1'b0;
    end else begin
      in_credit <= 1'b0;
      fs_valid <= replay_step;
      // Source may already send while credits are still going out
      if (in_valid) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      case (state)
        conv_pkg::FS_GRANTING: begin
          in_credit <= 1'b1;
          grant_cnt <= grant_cnt + 1'b1;
          if (grant_cnt == ADDR_W'(FRAME_SIZE - 1)) begin
            grant_cnt <= '0;
            state <= conv_pkg::FS_FILLING;
          end
        end
        conv_pkg::FS_FILLING: begin
          if (in_valid && wr_cnt == ADDR_W'(FRAME_SIZE - 1)) begin
            wr_cnt <= '0;
            state <= conv_pkg::FS_REPLAYING;
          end
        end
        default: begin
          if (replay_step) begin
            rd_addr <= rd_addr + 1'b1;
            pos_cnt <= pos_cnt + 1'b1;
            if (pos_cnt == POS_W'(IMAGE_SIZE - 1)) begin
              pos_cnt <= '0;
              ic_cnt <= (ic_cnt == CHANNEL_NUM_IN - 1) ? 1'b0 : ic_cnt + 1'b1;
            end
            // End of one output channel pass over the whole frame
            if (rd_addr == ADDR_W'(FRAME_SIZE - 1)) begin
              rd_addr <= '0;
              oc_cnt <= (oc_cnt == CHANNEL_NUM_OUT - 1) ? 1'b0 : oc_cnt + 1'b1;
              if (oc_cnt == CHANNEL_NUM_OUT - 1) begin
                state <= conv_pkg::FS_GRANTING;
              end
            end
          end
        end
      endcase
    end
  end

  // Frame memory and replay data
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_cnt] <= in_pixel;
    end
    if (replay_step) begin
      fs_pixel <= mem[rd_addr];
      fs_oc <= oc_cnt;
      fs_ic <= ic_cnt;
    end
  end

endmodule

// ==== source/conv_window_mac.sv ====
`timescale 1ns/1ns

module conv_window_mac #(
  parameter int IMAGE_WIDTH = conv_pkg::IMAGE_WIDTH,
  parameter int IMAGE_HEIGHT = conv_pkg::IMAGE_HEIGHT,
  parameter int CHANNEL_NUM_IN = conv_pkg::CHANNEL_NUM_IN,
  parameter int CHANNEL_NUM_OUT = conv_pkg::CHANNEL_NUM_OUT
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               weight_valid,
  input  conv_pkg::weight_t  weight,
  input  logic               fs_valid,
  input  conv_pkg::pixel_t   fs_pixel,
  input  logic               fs_oc,
  input  logic               fs_ic,
  output logic               mac_valid,
  output conv_pkg::partial_t mac_partial
);

  localparam int K = conv_pkg::KERNEL;
  localparam int KK = K * K;
  localparam int WEIGHT_NUM = CHANNEL_NUM_OUT * CHANNEL_NUM_IN * KK;
  localparam int W_IDX_W = $clog2(WEIGHT_NUM);
  localparam int COL_W = $clog2(IMAGE_WIDTH);
  localparam int ROW_W = $clog2(IMAGE_HEIGHT);

  conv_pkg::weight_t weight_mem [WEIGHT_NUM];
  logic [W_IDX_W-1:0] weight_cnt;
  logic [W_IDX_W-1:0] weight_base;
  // line0 holds the row above, line1 the row above that
  conv_pkg::pixel_t line0 [IMAGE_WIDTH];
  conv_pkg::pixel_t line1 [IMAGE_WIDTH];
  conv_pkg::pixel_t win [K][K];
  conv_pkg::pixel_t win_next [K][K];
  logic [COL_W-1:0] col_cnt;
  logic [ROW_W-1:0] row_cnt;
  logic window_done;
  conv_pkg::sum_t row_sum [K];
  conv_pkg::sum_t row_sum_q [K];
  logic s1_valid;
  logic s1_ic;
  logic s1_last;

  assign weight_base = W_IDX_W'((int'(fs_oc) * CHANNEL_NUM_IN + int'(fs_ic)) * KK);
  assign window_done = (row_cnt >= K - 1) && (col_cnt >= K - 1);

  //////////////////////////////
  // Weight load
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      weight_cnt <= '0;
    end else if (weight_valid) begin
      weight_cnt <= (weight_cnt == W_IDX_W'(WEIGHT_NUM - 1)) ? '0 : weight_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (weight_valid) begin
      weight_mem[weight_cnt] <= weight;
    end
  end

  //////////////////////////////
  // Window and products
  //////////////////////////////
  // Shift left and bring in the new column
  always_comb begin
    for (int r = 0; r < K; r++) begin
      for (int c = 0; c < K - 1; c++) begin
        win_next[r][c] = win[r][c+1];
      end
    end
    win_next[0][K-1] = line1[col_cnt];
    win_next[1][K-1] = line0[col_cnt];
    win_next[2][K-1] = fs_pixel;
  end

  // First adder stage, one sum per kernel row
  always_comb begin
    for (int r = 0; r < K; r++) begin
      row_sum[r] = '0;
      for (int c = 0; c < K; c++) begin
        row_sum[r] = row_sum[r] + conv_pkg::sum_t'(win_next[r][c] *
                     weight_mem[weight_base + W_IDX_W'(r * K + c)]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      col_cnt <= '0;
      row_cnt <= '0;
      s1_valid <= 1'b0;
      mac_valid <= 1'b0;
    end else begin
      s1_valid <= fs_valid && window_done;
      mac_valid <= s1_valid;
      if (fs_valid) begin
        col_cnt <= col_cnt + 1'b1;
        if (col_cnt == COL_W'(IMAGE_WIDTH - 1)) begin
          col_cnt <= '0;
          row_cnt <= (row_cnt == ROW_W'(IMAGE_HEIGHT - 1)) ? '0 : row_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fs_valid) begin
      win <= win_next;
      line0[col_cnt] <= fs_pixel;
      line1[col_cnt] <= line0[col_cnt];
      row_sum_q <= row_sum;
      s1_ic <= fs_ic;
      s1_last <= (fs_ic == CHANNEL_NUM_IN - 1);
    end
    if (s1_valid) begin
      mac_partial.value <= row_sum_q[0] + row_sum_q[1] + row_sum_q[2];
      mac_partial.ic <= s1_ic;
      mac_partial.last <= s1_last;
    end
  end

endmodule

// ==== source/conv_channel_adder.sv ====
`timescale 1ns/1ns

module conv_channel_adder #(
  parameter int IMAGE_WIDTH = conv_pkg::IMAGE_WIDTH,
  parameter int IMAGE_HEIGHT = conv_pkg::IMAGE_HEIGHT
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               mac_valid,
  input  conv_pkg::partial_t mac_partial,
  output logic               add_valid,
  output conv_pkg::sum_t     add_sum
);

  localparam int K = conv_pkg::KERNEL;
  localparam int OUT_SIZE = (IMAGE_WIDTH - K + 1) * (IMAGE_HEIGHT - K + 1);
  localparam int POS_W = $clog2(OUT_SIZE);

  // Running sums, one per output pixel of the current output channel
  conv_pkg::sum_t acc_mem [OUT_SIZE];
  logic [POS_W-1:0] pos_cnt;
  conv_pkg::sum_t acc_next;

  // Input channel 0 starts a new sum
  assign acc_next = (mac_partial.ic == 1'b0) ? mac_partial.value :
                    acc_mem[pos_cnt] + mac_partial.value;

  always_ff @(posedge clk) begin
    if (reset) begin
      pos_cnt <= '0;
      add_valid <= 1'b0;
    end else begin
      add_valid <= mac_valid && mac_partial.last;
      if (mac_valid) begin
        pos_cnt <= (pos_cnt == POS_W'(OUT_SIZE - 1)) ? '0 : pos_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mac_valid) begin
      acc_mem[pos_cnt] <= acc_next;
      if (mac_partial.last) begin
        add_sum <= acc_next;
      end
    end
  end

endmodule

// ==== source/conv_out_queue.sv ====
`timescale 1ns/1ns

module conv_out_queue #(
  parameter int QUEUE_DEPTH = 16,
  parameter int STALL_MARGIN = 4
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           add_valid,
  input  conv_pkg::sum_t add_sum,
  input  logic           out_credit,
  output logic           out_valid,
  output conv_pkg::sum_t out_sum,
  output logic           stall
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int CREDIT_W = 8;

  conv_pkg::sum_t mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CREDIT_W-1:0] credits;
  logic pop;

  // One result leaves per cycle while data and a credit are both held
  assign pop = (count != '0) && (credits != '0);
  assign out_valid = pop;
  assign out_sum = mem[rd_ptr];
  // Room kept for results still inside the pipeline
  assign stall = (QUEUE_DEPTH - int'(count)) < STALL_MARGIN;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= '0;
    end else begin
      if (add_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(add_valid) - CNT_W'(pop);
      credits <= credits + CREDIT_W'(out_credit) - CREDIT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (add_valid) begin
      mem[wr_ptr] <= add_sum;
    end
  end

endmodule

// ==== source/conv_layer_top.sv ====
`timescale 1ns/1ns

module conv_layer_top #(
  parameter int IMAGE_WIDTH = conv_pkg::IMAGE_WIDTH,
  parameter int IMAGE_HEIGHT = conv_pkg::IMAGE_HEIGHT,
  parameter int CHANNEL_NUM_IN = conv_pkg::CHANNEL_NUM_IN,
  parameter int CHANNEL_NUM_OUT = conv_pkg::CHANNEL_NUM_OUT,
  parameter int QUEUE_DEPTH = 16,
  parameter int STALL_MARGIN = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              weight_valid,
  input  conv_pkg::weight_t weight,
  input  logic              in_valid,
  input  conv_pkg::pixel_t  in_pixel,
  output logic              in_credit,
  input  logic              out_credit,
  output logic              out_valid,
  output conv_pkg::sum_t    out_sum
);

  logic fs_valid;
  conv_pkg::pixel_t fs_pixel;
  logic fs_oc;
  logic fs_ic;
  logic mac_valid;
  conv_pkg::partial_t mac_partial;
  logic add_valid;
  conv_pkg::sum_t add_sum;
  logic stall;

  //////////////////////////////
  // Frame store, MAC, adder, queue
  //////////////////////////////
  conv_frame_store #(
    .IMAGE_WIDTH    (IMAGE_WIDTH),
    .IMAGE_HEIGHT   (IMAGE_HEIGHT),
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
  ) u_frame_store (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .in_valid (in_valid),
    .in_pixel (in_pixel),
    .in_credit(in_credit),
    .fs_valid (fs_valid),
    .fs_pixel (fs_pixel),
    .fs_oc    (fs_oc),
    .fs_ic    (fs_ic)
  );

  conv_window_mac #(
    .IMAGE_WIDTH    (IMAGE_WIDTH),
    .IMAGE_HEIGHT   (IMAGE_HEIGHT),
    .CHANNEL_NUM_IN (CHANNEL_NUM_IN),
    .CHANNEL_NUM_OUT(CHANNEL_NUM_OUT)
  ) u_window_mac (
    .clk         (clk),
    .reset       (reset),
    .weight_valid(weight_valid),
    .weight      (weight),
    .fs_valid    (fs_valid),
    .fs_pixel    (fs_pixel),
    .fs_oc       (fs_oc),
    .fs_ic       (fs_ic),
    .mac_valid   (mac_valid),
    .mac_partial (mac_partial)
  );

  conv_channel_adder #(
    .IMAGE_WIDTH (IMAGE_WIDTH),
    .IMAGE_HEIGHT(IMAGE_HEIGHT)
  ) u_channel_adder (
    .clk        (clk),
    .reset      (reset),
    .mac_valid  (mac_valid),
    .mac_partial(mac_partial),
    .add_valid  (add_valid),
    .add_sum    (add_sum)
  );

  conv_out_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .STALL_MARGIN(STALL_MARGIN)
  ) u_out_queue (
    .clk       (clk),
    .reset     (reset),
    .add_valid (add_valid),
    .add_sum   (add_sum),
    .out_credit(out_credit),
    .out_valid (out_valid),
    .out_sum   (out_sum),
    .stall     (stall)
  );

endmodule

// ==== sim/conv_clock_gen.sv ====
`timescale 1ns/1ns

module conv_clock_gen #(
  parameter int HALF_PERIOD = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #HALF_PERIOD clk = ~clk;

endmodule

// ==== sim/conv_checker.sv ====
`timescale 1ns/1ns

module conv_checker (
  input logic           clk,
  input logic           reset,
  input logic           in_credit,
  input logic           out_credit,
  input logic           out_valid,
  input conv_pkg::sum_t out_sum
);

  conv_pkg::sum_t expected [$];
  string names [$];
  int pending = 0;
  int value_errors = 0;
  int other_errors = 0;
  int credit_run = 0;
  int credits_returned = 0;
  int results = 0;

  task automatic push_expected(input string name, input conv_pkg::sum_t value);
    expected.push_back(value);
    names.push_back(name);
    pending = expected.size();
  endtask

  task automatic print_summary(input int assertion_errors);
    $display("Checks done: %0d value, %0d other, %0d assertion errors, %0d results",
             value_errors, other_errors, assertion_errors, results);
  endtask

  // Compare outputs in arrival order
  always @(posedge clk) begin
    if (reset) begin
      if (in_credit || out_valid) begin
        $display("in_credit or out_valid was high during reset");
        other_errors++;
      end
    end else if (out_valid) begin
      if (results >= credits_returned) begin
        $display("A result came out without a returned output credit");
        other_errors++;
      end
      if (expected.size() == 0) begin
        $display("A result came out when none was expected");
        other_errors++;
      end else begin
        if (out_sum !== expected[0]) begin
          $display("[ERROR] %s: expected %0d, actual %0d", names[0], expected[0], out_sum);
          value_errors++;
        end
        void'(expected.pop_front());
        void'(names.pop_front());
        pending = expected.size();
      end
      results++;
    end
  end

  // Each grant is a run of exactly 50 credit pulses
  always @(posedge clk) begin
    if (!reset) begin
      if (out_credit) begin
        credits_returned <= credits_returned + 1;
      end
      if (in_credit) begin
        credit_run <= credit_run + 1;
      end else if (credit_run != 0) begin
        if (credit_run != 50) begin
          $display("A grant gave %0d input credits instead of 50", credit_run);
          other_errors++;
        end
        credit_run <= 0;
      end
    end
  end

endmodule

// ==== sim/conv_properties.sv ====
`timescale 1ns/1ns

module conv_properties (
  input logic           clk,
  input logic           reset,
  input logic           in_credit,
  input logic           in_valid,
  input logic           out_credit,
  input logic           out_valid,
  input conv_pkg::sum_t out_sum
);

  int in_held;
  int out_held;
  int failures = 0;

  always @(posedge clk) begin
    if (reset) begin
      in_held <= 0;
      out_held <= 0;
    end else begin
      in_held <= in_held + int'(in_credit) - int'(in_valid);
      out_held <= out_held + int'(out_credit) - int'(out_valid);
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    in_valid |-> (in_held + int'(in_credit)) > 0)
    else begin
      $error("Pixel sent without an input credit");
      failures++;
    end

  assert property (@(posedge clk) disable iff (reset) out_valid |-> out_held > 0)
    else begin
      $error("Output credits went below zero");
      failures++;
    end

  assert property (@(posedge clk) disable iff (reset) out_valid |-> !$isunknown(out_sum))
    else begin
      $error("out_sum unknown while out_valid is high");
      failures++;
    end

endmodule

bind conv_layer_top conv_properties props0 (
  .clk       (clk),
  .reset     (reset),
  .in_credit (in_credit),
  .in_valid  (in_valid),
  .out_credit(out_credit),
  .out_valid (out_valid),
  .out_sum   (out_sum)
);

// ==== sim/conv_tb.sv ====
`timescale 1ns/1ns

module conv_tb;

  localparam int FRAME_SIZE = 50;
  localparam int OUT_NUM = 18;
  // Two cases of about 300 cycles each, with a wide margin
  localparam int CYCLE_LIMIT = 2 * 1500;

  logic clk;
  logic reset;
  logic weight_valid;
  conv_pkg::weight_t weight;
  logic in_valid;
  conv_pkg::pixel_t in_pixel;
  logic in_credit;
  logic out_credit;
  logic out_valid;
  conv_pkg::sum_t out_sum;
  int granted;
  int used;
  int cycles;
  conv_pkg::pixel_t frame [FRAME_SIZE];

  conv_clock_gen clk_gen0 (.clk(clk));

  conv_layer_top #(
    .QUEUE_DEPTH (16),
    .STALL_MARGIN(4)
  ) dut0 (
    .clk         (clk),
    .reset       (reset),
    .weight_valid(weight_valid),
    .weight      (weight),
    .in_valid    (in_valid),
    .in_pixel    (in_pixel),
    .in_credit   (in_credit),
    .out_credit  (out_credit),
    .out_valid   (out_valid),
    .out_sum     (out_sum)
  );

  conv_checker checker0 (
    .clk       (clk),
    .reset     (reset),
    .in_credit (in_credit),
    .out_credit(out_credit),
    .out_valid (out_valid),
    .out_sum   (out_sum)
  );

  //////////////////////////////
  // Credits and run limit
  //////////////////////////////
  always @(posedge clk) begin
    if (reset) begin
      granted <= 0;
    end else if (in_credit) begin
      granted <= granted + 1;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  // Output credits come in bursts after pauses longer than the queue
  initial begin : credit_loop
    int pause;
    int burst;
    out_credit = 1'b0;
    wait (reset === 1'b0);
    forever begin
      pause = 17 + $urandom_range(0, 13);
      repeat (pause) @(posedge clk);
      burst = 1 + $urandom_range(0, 5);
      repeat (burst) begin
        @(posedge clk);
        #1 out_credit = 1'b1;
      end
      @(posedge clk);
      #1 out_credit = 1'b0;
    end
  end

  task automatic read_data_line(input int fd, output string line, output bit ok);
    ok = 1'b0;
    while (!$feof(fd)) begin
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        ok = 1'b1;
        return;
      end
    end
  endtask

  task automatic send_frame();
    int p;
    p = 0;
    while (p < FRAME_SIZE) begin
      @(posedge clk);
      #1;
      if (granted > used) begin
        in_valid = 1'b1;
        in_pixel = frame[p];
        used++;
        p++;
      end else begin
        in_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1 in_valid = 1'b0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int fd;
    int v [9];
    int errors;
    bit ok;
    string line;
    string name;
    void'($urandom(32'h9884));
    cycles = 0;
    used = 0;
    reset = 1'b1;
    weight_valid = 1'b0;
    weight = '0;
    in_valid = 1'b0;
    in_pixel = '0;
    fd = $fopen("sim/conv_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the cases file sim/conv_cases.txt");
      $display("Some tests failed");
      $finish;
    end
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
    read_data_line(fd, line, ok);
    while (ok) begin
      void'($sscanf(line, "case %s", name));
      // Nine weights per line
      for (int l = 0; l < 4; l++) begin
        read_data_line(fd, line, ok);
        void'($sscanf(line, "%d %d %d %d %d %d %d %d %d",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]));
        for (int k = 0; k < 9; k++) begin
          @(posedge clk);
          #1 weight_valid = 1'b1;
          weight = conv_pkg::weight_t'(v[k]);
        end
      end
      @(posedge clk);
      #1 weight_valid = 1'b0;
      for (int l = 0; l < 10; l++) begin
        read_data_line(fd, line, ok);
        void'($sscanf(line, "%d %d %d %d %d", v[0], v[1], v[2], v[3], v[4]));
        for (int k = 0; k < 5; k++) begin
          frame[l * 5 + k] = conv_pkg::pixel_t'(v[k]);
        end
      end
      for (int l = 0; l < OUT_NUM / 3; l++) begin
        read_data_line(fd, line, ok);
        void'($sscanf(line, "%d %d %d", v[0], v[1], v[2]));
        for (int k = 0; k < 3; k++) begin
          checker0.push_expected(name, conv_pkg::sum_t'(v[k]));
        end
      end
      send_frame();
      while (checker0.pending != 0) begin
        @(posedge clk);
      end
      read_data_line(fd, line, ok);
    end
    $fclose(fd);
    repeat (5) @(posedge clk);
    checker0.print_summary(dut0.props0.failures);
    errors = checker0.value_errors + checker0.other_errors + dut0.props0.failures;
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/conv_cases.txt ====
# Per case: "case name", 4 weight lines (oc, ic; 9 per line, row-major),
# 10 pixel rows (ic0 then ic1, 5 each), 6 expected rows (oc0 then oc1, 3 each)
case ramp
1 1 1 1 1 1 1 1 1
0 0 0 0 2 0 0 0 0
1 0 -1 1 0 -1 1 0 -1
-1 -1 -1 -1 -1 -1 -1 -1 -1
0 1 2 3 4
5 6 7 8 9
10 11 12 13 14
15 16 17 18 19
20 21 22 23 24
0 1 2 3 4
-1 0 1 2 3
-2 -1 0 1 2
-3 -2 -1 0 1
-4 -3 -2 -1 0
54 65 76
97 108 119
140 151 162
-6 -15 -24
3 -6 -15
12 3 -6
case mixed
1 1 1 0 0 0 -1 -1 -1
3 3 3 3 3 3 3 3 3
-2 -2 -2 -2 -2 -2 -2 -2 -2
0 0 0 0 -5 0 0 0 0
-20 -19 -18 -17 -16
-10 -9 -8 -7 -6
0 1 2 3 4
10 11 12 13 14
20 21 22 23 24
0 -3 -6 -9 -12
1 -2 -5 -8 -11
2 -1 -4 -7 -10
3 0 -3 -6 -9
4 1 -2 -5 -8
-114 -195 -276
-87 -168 -249
-60 -141 -222
172 169 166
-13 -16 -19
-198 -201 -204

// ==== list.f ====
source/conv_pkg.sv
source/conv_frame_store.sv
source/conv_window_mac.sv
source/conv_channel_adder.sv
source/conv_out_queue.sv
source/conv_layer_top.sv
sim/conv_clock_gen.sv
sim/conv_checker.sv
sim/conv_properties.sv
sim/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the convolution layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module conv_tb \
  -f list.f -o conv_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/conv_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1
